//--- clk_mgr_pkg.sv
package clk_mgr_pkg;

    parameter int CMD_DATA_W = 11;                 // command word, D1[2:0] over D0
    parameter int NUM_SRC    = 4;                  // external clock sources
    parameter int NUM_MON    = 3;                  // monitored input clocks
    parameter int PAYLOAD_W  = NUM_MON + NUM_SRC;  // {running, src_active}

    // bit 0 of the command address picks one of two registers
    typedef enum logic [0:0] {
        REG_CTRL   = 1'b0,  // resets, power-downs, monitor resets
        REG_STATUS = 1'b1   // status mode and sequence
    } reg_sel_e;

    // status packet sender
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,  // nothing queued
        ST_REQ  = 2'd1,  // rq up, address byte on the bus
        ST_B1   = 2'd2,  // {seq, payload[1:0]}
        ST_B2   = 2'd3   // upper payload bits
    } status_state_e;

    // wd[7:6] of a status write, code 2 is reserved and acts as off
    typedef enum logic [1:0] {
        MODE_OFF  = 2'd0,
        MODE_ONCE = 2'd1,
        MODE_AUTO = 2'd3
    } status_mode_e;

endpackage

//--- cmd_deser.sv
`timescale 1ns/1ps

module cmd_deser #(
    parameter logic [15:0] CMD_ADDR = 16'h728,  // base of the two-register block
    parameter logic [15:0] CMD_MASK = 16'h7fe   // bits that must agree with CMD_ADDR
) (
    input  logic                               mclk,
    input  logic                               rst,
    input  logic [7:0]                         cmd_ad_i,   // AL, AH, D0, D1
    input  logic                               cmd_stb_i,  // with AL only
    output clk_mgr_pkg::reg_sel_e              cmd_a_o,    // register offset
    output logic [clk_mgr_pkg::CMD_DATA_W-1:0] cmd_data_o, // {D1[2:0], D0}
    output logic                               cmd_we_o    // one cycle after D1
);

    logic [1:0]                         byte_cnt;      // index of the byte now on the bus
    logic                               busy;          // capture in progress
    logic [15:0]                        addr_sr;       // shifts in AL then AH
    logic [clk_mgr_pkg::CMD_DATA_W-1:0] data_sr;       // D0 low, D1 low bits high
    logic                               addr_hit;      // registered address compare
    logic                               addr_match_w;

    // only the bits set in the mask take part
    assign addr_match_w = ((addr_sr ^ CMD_ADDR) & CMD_MASK) == 16'h0000;

    assign cmd_a_o    = clk_mgr_pkg::reg_sel_e'(addr_sr[0]);  // held until next strobe
    assign cmd_data_o = data_sr;

    // byte counter, compare and write strobe
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            byte_cnt <= 2'd0;
            busy     <= 1'b0;
            addr_hit <= 1'b0;
            cmd_we_o <= 1'b0;
        end else begin
            cmd_we_o <= 1'b0;  // default, single-cycle pulse
            if (cmd_stb_i) begin  // new command always restarts
                byte_cnt <= 2'd1;
                busy     <= 1'b1;
                addr_hit <= 1'b0;
            end else if (busy) begin
                byte_cnt <= byte_cnt + 2'd1;
                if (byte_cnt == 2'd2) begin  // D0 on bus, AL/AH complete
                    addr_hit <= addr_match_w;
                end
                if (byte_cnt == 2'd3) begin  // D1 on bus, last byte
                    busy     <= 1'b0;
                    cmd_we_o <= addr_hit;
                end
            end
        end
    end

    // payload shift registers
    always_ff @(posedge mclk) begin
        if (cmd_stb_i || (busy && byte_cnt == 2'd1)) begin
            addr_sr <= {cmd_ad_i, addr_sr[15:8]};  // AL ends up low
        end
        if (!cmd_stb_i && busy && byte_cnt == 2'd2) begin
            data_sr[7:0] <= cmd_ad_i;  // D0
        end
        if (!cmd_stb_i && busy && byte_cnt == 2'd3) begin
            data_sr[clk_mgr_pkg::CMD_DATA_W-1:8] <= cmd_ad_i[clk_mgr_pkg::CMD_DATA_W-9:0];
        end
    end

    // write strobe is a single pulse per command
    a_we_single: assert property (
        @(posedge mclk) disable iff (rst)
        cmd_we_o |=> !cmd_we_o
    );

    // strobe for AL came exactly four cycles before the write
    a_we_after_stb: assert property (
        @(posedge mclk) disable iff (rst)
        cmd_we_o |-> $past(cmd_stb_i, 4)
    );

endmodule

//--- clk_ctrl_regs.sv
`timescale 1ns/1ps

module clk_ctrl_regs (
    input  logic                                mclk,
    input  logic                                rst,
    input  clk_mgr_pkg::reg_sel_e               cmd_a_i,
    input  logic [clk_mgr_pkg::CMD_DATA_W-1:0]  cmd_data_i,
    input  logic                                cmd_we_i,
    output logic [clk_mgr_pkg::NUM_SRC-1:0]     src_rst_o,     // per-source reset
    output logic [clk_mgr_pkg::NUM_SRC-1:0]     src_pwrdwn_o,  // per-source power-down
    output logic [clk_mgr_pkg::NUM_MON-1:0]     mon_rst_o,     // activity monitor resets
    output logic [clk_mgr_pkg::NUM_SRC-1:0]     src_active_o,  // neither reset nor powered down
    output logic                                status_we_o,   // status mode write, one cycle
    output logic [7:0]                          status_wd_o    // D0 of that write
);

    localparam int SRC = clk_mgr_pkg::NUM_SRC;

    logic [clk_mgr_pkg::CMD_DATA_W-1:0] ctrl_q;  // {mon_rst, pwrdwn, rst}
    logic                               set_ctrl_w;
    logic                               set_status_w;

    assign set_ctrl_w   = cmd_we_i && (cmd_a_i == clk_mgr_pkg::REG_CTRL);
    assign set_status_w = cmd_we_i && (cmd_a_i == clk_mgr_pkg::REG_STATUS);

    // field split
    assign src_rst_o    = ctrl_q[SRC-1:0];
    assign src_pwrdwn_o = ctrl_q[2*SRC-1:SRC];
    assign mon_rst_o    = ctrl_q[clk_mgr_pkg::CMD_DATA_W-1:2*SRC];
    assign src_active_o = ~(src_rst_o | src_pwrdwn_o);  // stands in for lock

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            ctrl_q      <= '0;    // everything released
            status_we_o <= 1'b0;
        end else begin
            status_we_o <= set_status_w;
            if (set_ctrl_w) begin
                ctrl_q <= cmd_data_i;
            end
        end
    end

    // mode byte only, upper bits are for the control register
    always_ff @(posedge mclk) begin
        if (set_status_w) begin
            status_wd_o <= cmd_data_i[7:0];
        end
    end

endmodule

//--- clk_monitor.sv
`timescale 1ns/1ps

module clk_monitor #(
    parameter int TREF_DIV_LOG2 = 3  // time_ref = mclk / 2**TREF_DIV_LOG2
) (
    input  logic                             mclk,
    input  logic                             rst,
    input  logic [clk_mgr_pkg::NUM_MON-1:0]  mon_clk_i,  // clocks under test
    input  logic [clk_mgr_pkg::NUM_MON-1:0]  mon_rst_i,  // hold toggles in reset
    output logic                             time_ref_o, // slow reference, not a global clock
    output logic [clk_mgr_pkg::NUM_MON-1:0]  running_o   // toggled during last window
);

    localparam int MON = clk_mgr_pkg::NUM_MON;

    logic [TREF_DIV_LOG2-1:0] pre_cnt;     // free-running prescaler
    logic                     tref_d;      // time_ref delayed one mclk
    logic                     tref_rise_w; // first cycle of time_ref high
    logic [MON-1:0]           tgl;         // toggles, one per foreign domain
    logic [MON-1:0]           tgl_rst_w;
    logic [MON-1:0]           sync1;       // first stage, may go metastable
    logic [MON-1:0]           sync2;       // safe in mclk
    logic [MON-1:0]           sync_d;      // previous sync2 for edge detect
    logic [MON-1:0]           chg_q;       // change seen in current window
    logic [MON-1:0]           chg_w;

    assign time_ref_o  = pre_cnt[TREF_DIV_LOG2-1];  // msb, starts low
    assign tref_rise_w = time_ref_o & ~tref_d;
    assign tgl_rst_w   = mon_rst_i | {MON{rst}};    // core reset also clears toggles
    assign chg_w       = sync2 ^ sync_d;

    // one toggle flip-flop in each monitored clock domain
    for (genvar k = 0; k < MON; k++) begin : g_tgl
        logic tgl_q;

        always_ff @(posedge mon_clk_i[k] or posedge tgl_rst_w[k]) begin
            if (tgl_rst_w[k]) begin
                tgl_q <= 1'b0;
            end else begin
                tgl_q <= ~tgl_q;  // half rate of the monitored clock
            end
        end

        assign tgl[k] = tgl_q;
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            pre_cnt   <= '0;
            tref_d    <= 1'b0;
            sync1     <= '0;
            sync2     <= '0;
            sync_d    <= '0;
            chg_q     <= '0;
            running_o <= '0;
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
            tref_d  <= time_ref_o;
            sync1   <= tgl;      // crossing into mclk
            sync2   <= sync1;
            sync_d  <= sync2;
            if (tref_rise_w) begin  // window closes
                running_o <= chg_q | chg_w;
                chg_q     <= '0;
            end else begin
                chg_q <= chg_q | chg_w;  // sticky within the window
            end
        end
    end

    // verdict only moves once per time_ref period
    a_running_on_window: assert property (
        @(posedge mclk) disable iff (rst)
        (running_o != $past(running_o)) |-> $past(tref_rise_w)
    );

endmodule

//--- status_generate.sv
`timescale 1ns/1ps

module status_generate #(
    parameter logic [7:0] STATUS_REG_ADDR = 8'h3a  // first byte of every packet
) (
    input  logic                              mclk,
    input  logic                              rst,
    input  logic                              we_i,           // mode/sequence write
    input  logic [7:0]                        wd_i,           // {mode[1:0], seq[5:0]}
    input  logic [clk_mgr_pkg::PAYLOAD_W-1:0] payload_i,      // {running, src_active}
    input  logic                              status_start_i, // downstream took the address
    output logic [7:0]                        status_ad_o,    // byte-serial status
    output logic                              status_rq_o     // packet waiting
);

    localparam int PW = clk_mgr_pkg::PAYLOAD_W;

    clk_mgr_pkg::status_state_e state;
    clk_mgr_pkg::status_mode_e  mode_q;
    clk_mgr_pkg::status_mode_e  wd_mode_w;
    logic [5:0]                 seq_q;       // sequence number sent in byte 1
    logic [PW-1:0]              sent_q;      // payload of the last packet
    logic                       pend_q;      // send requested while a packet was going out
    logic                       wr_send_w;
    logic                       wr_off_w;
    logic                       auto_chg_w;
    logic                       want_w;

    assign wd_mode_w  = clk_mgr_pkg::status_mode_e'(wd_i[7:6]);
    assign wr_send_w  = we_i && (wd_mode_w == clk_mgr_pkg::MODE_ONCE ||
                                 wd_mode_w == clk_mgr_pkg::MODE_AUTO);
    assign wr_off_w   = we_i && !wr_send_w;  // off or reserved code
    assign auto_chg_w = (mode_q == clk_mgr_pkg::MODE_AUTO) && (payload_i != sent_q) && !we_i;
    assign want_w     = wr_send_w || auto_chg_w || (pend_q && !wr_off_w);

    // mode and sequence
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            mode_q <= clk_mgr_pkg::MODE_OFF;
            seq_q  <= 6'd0;
        end else if (we_i) begin
            mode_q <= wd_mode_w;
            seq_q  <= wd_i[5:0];
        end
    end

    // packet sender
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            state       <= clk_mgr_pkg::ST_IDLE;
            status_rq_o <= 1'b0;
            status_ad_o <= 8'h00;
            sent_q      <= '0;
            pend_q      <= 1'b0;
        end else begin
            if (wr_off_w) begin
                pend_q <= 1'b0;  // off drops anything queued
            end else if (wr_send_w && (state == clk_mgr_pkg::ST_B1 ||
                                       state == clk_mgr_pkg::ST_B2)) begin
                pend_q <= 1'b1;  // too late for this packet, queue one more
            end
            case (state)
                clk_mgr_pkg::ST_IDLE: begin
                    if (want_w) begin
                        state       <= clk_mgr_pkg::ST_REQ;
                        status_rq_o <= 1'b1;
                        status_ad_o <= STATUS_REG_ADDR;
                        pend_q      <= 1'b0;
                    end
                end
                clk_mgr_pkg::ST_REQ: begin  // later changes merge here
                    if (status_start_i) begin
                        state       <= clk_mgr_pkg::ST_B1;
                        status_rq_o <= 1'b0;
                        status_ad_o <= {seq_q, payload_i[1:0]};
                        sent_q      <= payload_i;  // snapshot at start
                    end
                end
                clk_mgr_pkg::ST_B1: begin
                    state       <= clk_mgr_pkg::ST_B2;
                    status_ad_o <= {{(10 - PW){1'b0}}, sent_q[PW-1:2]};
                end
                clk_mgr_pkg::ST_B2: begin
                    state       <= clk_mgr_pkg::ST_IDLE;
                    status_ad_o <= 8'h00;  // bus quiet between packets
                end
                default: begin
                    state       <= clk_mgr_pkg::ST_IDLE;
                    status_rq_o <= 1'b0;
                    status_ad_o <= 8'h00;
                end
            endcase
        end
    end

    // request is never withdrawn before start, even by a mode-off write
    a_rq_held: assert property (
        @(posedge mclk) disable iff (rst)
        (status_rq_o && !status_start_i) |=> status_rq_o
    );

endmodule

//--- clk_mgr_top.sv
`timescale 1ns/1ps

module clk_mgr_top #(
    parameter logic [15:0] CMD_ADDR        = 16'h728,  // control at 'h728, status mode 'h729
    parameter logic [15:0] CMD_MASK        = 16'h7fe,
    parameter logic [7:0]  STATUS_REG_ADDR = 8'h3a,
    parameter int          TREF_DIV_LOG2   = 3         // mclk/8 reference
) (
    input  logic                             mclk,
    input  logic                             rst,
    input  logic [7:0]                       cmd_ad_i,
    input  logic                             cmd_stb_i,
    input  logic                             status_start_i,
    input  logic [clk_mgr_pkg::NUM_MON-1:0]  mon_clk_i,
    output logic [7:0]                       status_ad_o,
    output logic                             status_rq_o,
    output logic [clk_mgr_pkg::NUM_SRC-1:0]  src_rst_o,
    output logic [clk_mgr_pkg::NUM_SRC-1:0]  src_pwrdwn_o,
    output logic                             time_ref_o
);

    clk_mgr_pkg::reg_sel_e               cmd_a;
    logic [clk_mgr_pkg::CMD_DATA_W-1:0]  cmd_data;
    logic                                cmd_we;
    logic [clk_mgr_pkg::NUM_MON-1:0]     mon_rst;
    logic [clk_mgr_pkg::NUM_SRC-1:0]     src_active;
    logic                                status_we;
    logic [7:0]                          status_wd;
    logic [clk_mgr_pkg::NUM_MON-1:0]     running;
    logic [clk_mgr_pkg::PAYLOAD_W-1:0]   payload;

    assign payload = {running, src_active};  // monitors above sources

    cmd_deser #(
        .CMD_ADDR   (CMD_ADDR),
        .CMD_MASK   (CMD_MASK)
    ) u_cmd_deser (
        .mclk       (mclk),
        .rst        (rst),
        .cmd_ad_i   (cmd_ad_i),
        .cmd_stb_i  (cmd_stb_i),
        .cmd_a_o    (cmd_a),
        .cmd_data_o (cmd_data),
        .cmd_we_o   (cmd_we)
    );

    clk_ctrl_regs u_clk_ctrl_regs (
        .mclk         (mclk),
        .rst          (rst),
        .cmd_a_i      (cmd_a),
        .cmd_data_i   (cmd_data),
        .cmd_we_i     (cmd_we),
        .src_rst_o    (src_rst_o),
        .src_pwrdwn_o (src_pwrdwn_o),
        .mon_rst_o    (mon_rst),
        .src_active_o (src_active),
        .status_we_o  (status_we),
        .status_wd_o  (status_wd)
    );

    clk_monitor #(
        .TREF_DIV_LOG2 (TREF_DIV_LOG2)
    ) u_clk_monitor (
        .mclk       (mclk),
        .rst        (rst),
        .mon_clk_i  (mon_clk_i),
        .mon_rst_i  (mon_rst),
        .time_ref_o (time_ref_o),
        .running_o  (running)
    );

    status_generate #(
        .STATUS_REG_ADDR (STATUS_REG_ADDR)
    ) u_status_generate (
        .mclk           (mclk),
        .rst            (rst),
        .we_i           (status_we),
        .wd_i           (status_wd),
        .payload_i      (payload),
        .status_start_i (status_start_i),
        .status_ad_o    (status_ad_o),
        .status_rq_o    (status_rq_o)
    );

endmodule

//--- tb_clk_mgr.sv
`timescale 1ns/1ps

module tb_clk_mgr;

    localparam logic [15:0] CMD_ADDR    = 16'h728;
    localparam logic [15:0] CMD_MASK    = 16'h7fe;
    localparam logic [15:0] STAT_CMD    = CMD_ADDR | 16'h0001;  // offset 1, status mode
    localparam logic [7:0]  STATUS_ADDR = 8'h3a;
    localparam int          CYCLE_LIMIT = 4000;  // tests need well under 1000 cycles

    logic        mclk = 1'b0;
    logic        rst;
    logic [7:0]  cmd_ad;
    logic        cmd_stb;
    logic        status_start;
    logic        mon_clk0 = 1'b0;
    logic        mon_clk1 = 1'b0;
    logic        mon_clk2 = 1'b0;
    logic [2:0]  mon_en;          // gate per monitored clock
    logic [2:0]  mon_clk;
    logic [7:0]  status_ad;
    logic        status_rq;
    logic [3:0]  src_rst;
    logic [3:0]  src_pwrdwn;
    logic        time_ref;

    logic [10:0] ctrl_model = 11'h000;   // expected control register
    logic [31:0] lfsr_q = 32'h90d81a4e;
    int          errors = 0;
    int          checks = 0;
    int          cycle_cnt = 0;

    always #5 mclk = ~mclk;
    always #6.5 mon_clk0 = mon_en[0] ? ~mon_clk0 : mon_clk0;   // 13 ns
    always #8.5 mon_clk1 = mon_en[1] ? ~mon_clk1 : mon_clk1;   // 17 ns
    always #11.5 mon_clk2 = mon_en[2] ? ~mon_clk2 : mon_clk2;  // 23 ns

    assign mon_clk = {mon_clk2, mon_clk1, mon_clk0};

    clk_mgr_top #(
        .CMD_ADDR        (CMD_ADDR),
        .CMD_MASK        (CMD_MASK),
        .STATUS_REG_ADDR (STATUS_ADDR),
        .TREF_DIV_LOG2   (3)
    ) i_dut (
        .mclk           (mclk),
        .rst            (rst),
        .cmd_ad_i       (cmd_ad),
        .cmd_stb_i      (cmd_stb),
        .status_start_i (status_start),
        .mon_clk_i      (mon_clk),
        .status_ad_o    (status_ad),
        .status_rq_o    (status_rq),
        .src_rst_o      (src_rst),
        .src_pwrdwn_o   (src_pwrdwn),
        .time_ref_o     (time_ref)
    );

    // watchdog
    always @(posedge mclk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            val    = {val[30:0], lfsr_q[0]};  // one step per bit
        end
    endtask

    function automatic logic [10:0] status_word(input logic [1:0] mode, input logic [5:0] seq);
        return {3'b000, mode, seq};  // mode lands in D0[7:6]
    endfunction

    task automatic show_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        $display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
        errors++;
    endtask

    task automatic note_failure(input string what);
        $display("t=%0t error: %s", $time, what);
        errors++;
    endtask

    // outputs settle at the edge, inputs change 1 ns later
    task automatic step();
        @(posedge mclk);
        #1;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) step();
    endtask

    // AL, AH, D0, D1, then two cycles to the control outputs
    task automatic send_cmd(input logic [15:0] addr, input logic [10:0] data,
                            input logic accept);  // address expected to match
        cmd_stb = 1'b1;
        cmd_ad  = addr[7:0];
        step();
        cmd_stb = 1'b0;
        cmd_ad  = addr[15:8];
        step();
        cmd_ad = data[7:0];
        step();
        cmd_ad = {5'b00000, data[10:8]};
        step();
        cmd_ad = 8'h00;
        if (accept && !addr[0]) begin
            ctrl_model = data;  // offset 0 is the control register
        end
        step();
        checks += 2;
        if (src_rst !== ctrl_model[3:0])
            show_mismatch("src_rst_o", 32'(src_rst), 32'(ctrl_model[3:0]));
        if (src_pwrdwn !== ctrl_model[7:4])
            show_mismatch("src_pwrdwn_o", 32'(src_pwrdwn), 32'(ctrl_model[7:4]));
    endtask

    task automatic wait_rq(output logic seen);
        int waited;
        waited = 0;
        while (status_rq !== 1'b1 && waited < 40) begin
            step();
            waited++;
        end
        seen = (status_rq === 1'b1);
        if (!seen)
            note_failure("status request did not rise within 40 cycles");
    endtask

    task automatic hold_rq_high(input int n);
        repeat (n) begin
            step();
            checks++;
            if (status_rq !== 1'b1)
                show_mismatch("status_rq_o (held)", 32'(status_rq), 1);
        end
    endtask

    task automatic expect_rq_low(input int n);
        repeat (n) begin
            step();
            checks++;
            if (status_rq !== 1'b0)
                show_mismatch("status_rq_o (idle)", 32'(status_rq), 0);
        end
    endtask

    // request, start pulse, then the two payload bytes
    task automatic get_status(input logic [5:0] seq, input logic [2:0] run_exp);
        logic [6:0] payload;
        logic [7:0] b1_exp;
        logic [7:0] b2_exp;
        logic       seen;
        payload = {run_exp, ~(ctrl_model[3:0] | ctrl_model[7:4])};  // active = not rst/pd
        b1_exp  = {seq, payload[1:0]};
        b2_exp  = {3'b000, payload[6:2]};
        wait_rq(seen);
        if (seen) begin
            checks++;
            if (status_ad !== STATUS_ADDR)
                show_mismatch("status_ad_o (address)", 32'(status_ad), 32'(STATUS_ADDR));
            status_start = 1'b1;
            step();
            status_start = 1'b0;
            checks += 2;
            if (status_ad !== b1_exp)
                show_mismatch("status_ad_o (byte 1)", 32'(status_ad), 32'(b1_exp));
            if (status_rq !== 1'b0)
                show_mismatch("status_rq_o (after start)", 32'(status_rq), 0);
            step();
            checks++;
            if (status_ad !== b2_exp)
                show_mismatch("status_ad_o (byte 2)", 32'(status_ad), 32'(b2_exp));
        end
    endtask

    task automatic check_reset_state();
        logic exp_tref;
        checks += 5;
        if (status_rq !== 1'b0)
            show_mismatch("status_rq_o", 32'(status_rq), 0);
        if (src_rst !== 4'h0)
            show_mismatch("src_rst_o", 32'(src_rst), 0);
        if (src_pwrdwn !== 4'h0)
            show_mismatch("src_pwrdwn_o", 32'(src_pwrdwn), 0);
        if (time_ref !== 1'b0)
            show_mismatch("time_ref_o", 32'(time_ref), 0);
        if (status_ad !== 8'h00)
            show_mismatch("status_ad_o", 32'(status_ad), 0);
        for (int n = 1; n <= 32; n++) begin
            step();
            exp_tref = n[2];  // mclk/8, low for the first four edges
            checks++;
            if (time_ref !== exp_tref)
                show_mismatch("time_ref_o", 32'(time_ref), 32'(exp_tref));
        end
    endtask

    task automatic exercise_ctrl_writes();
        logic [31:0] r;
        for (int i = 0; i < 6; i++) begin
            rand_bits(11, r);
            send_cmd(CMD_ADDR, r[10:0], 1'b1);
        end
        rand_bits(11, r);
        send_cmd(16'h0738, r[10:0], 1'b0);  // bit 4 differs, ignored
        rand_bits(11, r);
        send_cmd(16'h0328, r[10:0], 1'b0);  // bit 10 differs, ignored
        rand_bits(11, r);
        send_cmd(16'hf728, r[10:0], 1'b1);  // upper nibble is outside the mask, accepted
    endtask

    task automatic single_packet();
        logic [31:0] r;
        rand_bits(8, r);
        send_cmd(CMD_ADDR, {3'b000, r[7:0]}, 1'b1);  // monitors out of reset
        wait_cycles(32);                             // three windows plus sync
        send_cmd(STAT_CMD, status_word(clk_mgr_pkg::MODE_ONCE, 6'd5), 1'b1);
        get_status(6'd5, 3'b111);
        expect_rq_low(12);  // once means one packet
    endtask

    task automatic clock_monitoring();
        mon_en[1] = 1'b0;  // stop clock 1
        wait_cycles(32);
        send_cmd(STAT_CMD, status_word(clk_mgr_pkg::MODE_ONCE, 6'd6), 1'b1);
        get_status(6'd6, 3'b101);
        send_cmd(CMD_ADDR, {3'b100, ctrl_model[7:0]}, 1'b1);  // hold monitor 2 in reset
        wait_cycles(32);
        send_cmd(STAT_CMD, status_word(clk_mgr_pkg::MODE_ONCE, 6'd7), 1'b1);
        get_status(6'd7, 3'b001);
        mon_en[1] = 1'b1;
        send_cmd(CMD_ADDR, {3'b000, ctrl_model[7:0]}, 1'b1);
        wait_cycles(32);
        send_cmd(STAT_CMD, status_word(clk_mgr_pkg::MODE_ONCE, 6'd8), 1'b1);
        get_status(6'd8, 3'b111);
    endtask

    task automatic auto_and_backpressure();
        logic seen;
        send_cmd(CMD_ADDR, 11'h000, 1'b1);  // all sources active
        send_cmd(STAT_CMD, status_word(clk_mgr_pkg::MODE_AUTO, 6'd9), 1'b1);
        get_status(6'd9, 3'b111);
        expect_rq_low(10);
        send_cmd(CMD_ADDR, 11'h021, 1'b1);  // src 0 reset, src 1 down
        get_status(6'd9, 3'b111);
        send_cmd(CMD_ADDR, 11'h004, 1'b1);  // src 2 reset only
        wait_rq(seen);
        hold_rq_high(20);                   // start withheld
        send_cmd(CMD_ADDR, 11'h0c0, 1'b1);  // second change merges into the pending packet
        hold_rq_high(30);
        get_status(6'd9, 3'b111);
        send_cmd(STAT_CMD, status_word(clk_mgr_pkg::MODE_OFF, 6'd10), 1'b1);
        send_cmd(CMD_ADDR, 11'h000, 1'b1);
        expect_rq_low(30);
    endtask

    initial begin
        rst          = 1'b1;
        cmd_ad       = 8'h00;
        cmd_stb      = 1'b0;
        status_start = 1'b0;
        mon_en       = 3'b111;
        repeat (5) @(posedge mclk);
        #1;
        rst = 1'b0;

        check_reset_state();
        exercise_ctrl_writes();
        single_packet();
        clock_monitoring();
        auto_and_backpressure();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- clk_mgr.f
clk_mgr_pkg.sv
cmd_deser.sv
clk_ctrl_regs.sv
clk_monitor.sv
status_generate.sv
clk_mgr_top.sv
tb_clk_mgr.sv

//--- run_sim.sh
#!/bin/sh
# compile the clock manager with its testbench, run it, judge by the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_clk_mgr -f clk_mgr.f -o tb_clk_mgr \
    > build.log 2>&1 \
    && ./obj_dir/tb_clk_mgr > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
